//--- rv32i_macros.svh
`ifndef RV32I_MACROS_SVH
`define RV32I_MACROS_SVH

// data and address word width.
`define XLEN 32

// register index width.
`define REG_ADDR_W 5

// architectural integer registers including x0.
`define NUM_REGS 32

// data memory depth in words.
`define DMEM_WORDS 256

// word index width as log2 of the depth.
`define DMEM_ADDR_W 8

`endif

//--- rv32i_types.sv
`include "rv32i_macros.svh"

package rv32i_types;

    typedef logic [`XLEN-1:0] word_t;
    typedef logic [`REG_ADDR_W-1:0] reg_idx_t;
    typedef logic [(`XLEN/8)-1:0] byte_en_t;

    // source of the value written back to rd.
    typedef enum logic [3:0] {
        alu_out_wb  = 4'd0,
        br_en_wb    = 4'd1,
        u_imm_wb    = 4'd2,
        lw_wb       = 4'd3,
        pc_plus4_wb = 4'd4,
        lb_wb       = 4'd5,
        lbu_wb      = 4'd6,
        lh_wb       = 4'd7,
        lhu_wb      = 4'd8
    } regf_m_sel_t;

    // store access size.
    typedef enum logic [1:0] {
        mem_b = 2'd0,
        mem_h = 2'd1,
        mem_w = 2'd2
    } mem_width_t;

    typedef struct packed {
        regf_m_sel_t    regf_m_sel;
        logic           regf_we;
    } wb_signal_t;

    typedef struct packed {
        logic           valid;
        word_t          pc;
        word_t          alu_out;
        word_t          br_en;
        word_t          u_imm;
        word_t          rs2_v;
        reg_idx_t       rd_s;
        logic           mem_we;
        mem_width_t     mem_width;
        wb_signal_t     wb_signal;
    } ex_mem_stage_reg_t;

    typedef struct packed {
        logic           valid;
        word_t          pc;
        word_t          alu_out;
        word_t          br_en;
        word_t          u_imm;
        word_t          lw;
        word_t          lb;
        word_t          lbu;
        word_t          lh;
        word_t          lhu;
        reg_idx_t       rd_s;
        wb_signal_t     wb_signal;
    } mem_wb_stage_reg_t;

endpackage

//--- regf_wr_if.sv
`timescale 1ns/1ns

interface regf_wr_if
    import rv32i_types::*;
();

    reg_idx_t   rd_s;
    word_t      rd_v;
    logic       regf_we;
    logic       valid;

    // write-back stage side.
    modport src (
        output rd_s,
        output rd_v,
        output regf_we,
        output valid
    );

    // register file side.
    modport dst (
        input rd_s,
        input rd_v,
        input regf_we,
        input valid
    );

endinterface

//--- data_mem.sv
`timescale 1ns/1ns
`include "rv32i_macros.svh"

module data_mem
    import rv32i_types::*;
(
    input  logic                    clk,
    input  logic [`DMEM_ADDR_W-1:0] addr,
    input  word_t                   wdata,
    input  byte_en_t                byte_en,
    input  logic                    we,
    output word_t                   rdata
);

    word_t mem [`DMEM_WORDS];

    // asynchronous read of the addressed word.
    assign rdata = mem[addr];

    // only the enabled byte lanes are updated.
    always_ff @(posedge clk) begin
        if (we) begin
            for (int i = 0; i < `XLEN/8; i++) begin
                if (byte_en[i]) begin
                    mem[addr][i*8 +: 8] <= wdata[i*8 +: 8];
                end
            end
        end
    end

endmodule

//--- mem_stage.sv
`timescale 1ns/1ns
`include "rv32i_macros.svh"

module mem_stage
    import rv32i_types::*;
(
    input  logic                clk,
    input  logic                rst_n,
    input  ex_mem_stage_reg_t   ex_in,
    output mem_wb_stage_reg_t   mem_wb_stage_reg
);

    ex_mem_stage_reg_t  ex_mem;
    mem_wb_stage_reg_t  mem_wb_next;

    logic [1:0]         offset;
    logic [`DMEM_ADDR_W-1:0] word_idx;
    word_t              store_data;
    byte_en_t           byte_en;
    logic               mem_wr;
    word_t              rd_word;
    logic [7:0]         load_byte;
    logic [15:0]        load_half;

    // EX/MEM register.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_mem.valid <= 1'b0;
        end else begin
            ex_mem <= ex_in;
        end
    end

    assign offset   = ex_mem.alu_out[1:0];
    assign word_idx = ex_mem.alu_out[`DMEM_ADDR_W+1:2];
    assign mem_wr   = ex_mem.valid & ex_mem.mem_we;

    // replicate store data across the lanes it may land in.
    always_comb begin
        store_data = ex_mem.rs2_v;
        byte_en    = '0;
        case (ex_mem.mem_width)
            mem_b: begin
                store_data = {4{ex_mem.rs2_v[7:0]}};
                byte_en    = byte_en_t'(4'b0001 << offset);
            end
            mem_h: begin
                store_data = {2{ex_mem.rs2_v[15:0]}};
                byte_en    = offset[1] ? 4'b1100 : 4'b0011;
            end
            mem_w: begin
                byte_en = 4'b1111;
            end
            default: begin
                byte_en = '0;
            end
        endcase
    end

    data_mem u_data_mem (
        .clk     (clk),
        .addr    (word_idx),
        .wdata   (store_data),
        .byte_en (byte_en),
        .we      (mem_wr),
        .rdata   (rd_word)
    );

    assign load_byte = rd_word[{offset, 3'b000} +: 8];
    assign load_half = offset[1] ? rd_word[31:16] : rd_word[15:0];

    always_comb begin
        mem_wb_next.valid     = ex_mem.valid;
        mem_wb_next.pc        = ex_mem.pc;
        mem_wb_next.alu_out   = ex_mem.alu_out;
        mem_wb_next.br_en     = ex_mem.br_en;
        mem_wb_next.u_imm     = ex_mem.u_imm;
        mem_wb_next.lw        = rd_word;
        mem_wb_next.lb        = {{(`XLEN-8){load_byte[7]}}, load_byte};
        mem_wb_next.lbu       = {{(`XLEN-8){1'b0}}, load_byte};
        mem_wb_next.lh        = {{(`XLEN-16){load_half[15]}}, load_half};
        mem_wb_next.lhu       = {{(`XLEN-16){1'b0}}, load_half};
        mem_wb_next.rd_s      = ex_mem.rd_s;
        mem_wb_next.wb_signal = ex_mem.wb_signal;
    end

    // MEM/WB register.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_wb_stage_reg.valid <= 1'b0;
        end else begin
            mem_wb_stage_reg <= mem_wb_next;
        end
    end

endmodule

//--- wb_stage.sv
`timescale 1ns/1ns

module wb_stage
    import rv32i_types::*;
(
    input  mem_wb_stage_reg_t   mem_wb_stage_reg,
    regf_wr_if.src              wr
);

    wb_signal_t wb_signal;
    word_t      pc_plus4;
    word_t      wb_val;

    assign wb_signal = mem_wb_stage_reg.wb_signal;

    // link value for jal and jalr.
    assign pc_plus4 = mem_wb_stage_reg.pc + word_t'(4);

    always_comb begin
        wb_val = '0;
        case (wb_signal.regf_m_sel)
            alu_out_wb: begin
                wb_val = mem_wb_stage_reg.alu_out;
            end
            br_en_wb: begin
                wb_val = mem_wb_stage_reg.br_en;
            end
            u_imm_wb: begin
                wb_val = mem_wb_stage_reg.u_imm;
            end
            lw_wb: begin
                wb_val = mem_wb_stage_reg.lw;
            end
            pc_plus4_wb: begin
                wb_val = pc_plus4;
            end
            lb_wb: begin
                wb_val = mem_wb_stage_reg.lb;
            end
            lbu_wb: begin
                wb_val = mem_wb_stage_reg.lbu;
            end
            lh_wb: begin
                wb_val = mem_wb_stage_reg.lh;
            end
            lhu_wb: begin
                wb_val = mem_wb_stage_reg.lhu;
            end
            default: begin
                wb_val = '0;
            end
        endcase
    end

    assign wr.rd_s    = mem_wb_stage_reg.rd_s;
    assign wr.rd_v    = wb_val;
    assign wr.regf_we = wb_signal.regf_we;
    assign wr.valid   = mem_wb_stage_reg.valid;

endmodule

//--- regfile.sv
`timescale 1ns/1ns
`include "rv32i_macros.svh"

module regfile
    import rv32i_types::*;
(
    input  logic        clk,
    input  logic        rst_n,
    regf_wr_if.dst      wr,
    input  reg_idx_t    rs1_s,
    input  reg_idx_t    rs2_s,
    output word_t       rs1_v,
    output word_t       rs2_v
);

    // x0 has no storage.
    word_t  regs [1:`NUM_REGS-1];
    logic   wr_en;

    assign wr_en = wr.valid & wr.regf_we & (wr.rd_s != '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < `NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_en) begin
            regs[wr.rd_s] <= wr.rd_v;
        end
    end

    // same-cycle write forwarded to the read ports.
    always_comb begin
        if (rs1_s == '0) begin
            rs1_v = '0;
        end else if (wr_en && (rs1_s == wr.rd_s)) begin
            rs1_v = wr.rd_v;
        end else begin
            rs1_v = regs[rs1_s];
        end

        if (rs2_s == '0) begin
            rs2_v = '0;
        end else if (wr_en && (rs2_s == wr.rd_s)) begin
            rs2_v = wr.rd_v;
        end else begin
            rs2_v = regs[rs2_s];
        end
    end

endmodule

//--- rv32i_backend.sv
`timescale 1ns/1ns

module rv32i_backend
    import rv32i_types::*;
(
    input  logic        clk,
    input  logic        rst_n,
    input  logic        in_valid,
    input  word_t       in_pc,
    input  word_t       in_alu_out,
    input  word_t       in_br_en,
    input  word_t       in_u_imm,
    input  word_t       in_rs2_v,
    input  reg_idx_t    in_rd_s,
    input  logic        in_mem_we,
    input  mem_width_t  in_mem_width,
    input  regf_m_sel_t in_regf_m_sel,
    input  logic        in_regf_we,
    input  reg_idx_t    rs1_s,
    input  reg_idx_t    rs2_s,
    output word_t       rs1_v,
    output word_t       rs2_v,
    output reg_idx_t    wb_rd_s,
    output word_t       wb_rd_v,
    output logic        wb_regf_we
);

    ex_mem_stage_reg_t  ex_in;
    mem_wb_stage_reg_t  mem_wb;

    regf_wr_if wr_bus ();

    // executed instruction into stage register form.
    always_comb begin
        ex_in.valid                = in_valid;
        ex_in.pc                   = in_pc;
        ex_in.alu_out              = in_alu_out;
        ex_in.br_en                = in_br_en;
        ex_in.u_imm                = in_u_imm;
        ex_in.rs2_v                = in_rs2_v;
        ex_in.rd_s                 = in_rd_s;
        ex_in.mem_we               = in_mem_we;
        ex_in.mem_width            = in_mem_width;
        ex_in.wb_signal.regf_m_sel = in_regf_m_sel;
        ex_in.wb_signal.regf_we    = in_regf_we;
    end

    mem_stage u_mem_stage (
        .clk              (clk),
        .rst_n            (rst_n),
        .ex_in            (ex_in),
        .mem_wb_stage_reg (mem_wb)
    );

    wb_stage u_wb_stage (
        .mem_wb_stage_reg (mem_wb),
        .wr               (wr_bus.src)
    );

    regfile u_regfile (
        .clk   (clk),
        .rst_n (rst_n),
        .wr    (wr_bus.dst),
        .rs1_s (rs1_s),
        .rs2_s (rs2_s),
        .rs1_v (rs1_v),
        .rs2_v (rs2_v)
    );

    assign wb_rd_s    = wr_bus.rd_s;
    assign wb_rd_v    = wr_bus.rd_v;
    assign wb_regf_we = wr_bus.regf_we & wr_bus.valid;

endmodule

//--- tb_rv32i_backend.sv
`timescale 1ns/1ns
`include "rv32i_macros.svh"

module tb_rv32i_backend
    import rv32i_types::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int N_ALU = 200;
    localparam int N_MEM = 150;
    localparam int N_SUP = 100;
    localparam int N_BYP = 100;
    localparam int TOTAL_CYCLES = 9 + 32 + (N_ALU + 32) + (16 + 2 * N_MEM + 32)
                                + (N_SUP + 16 + 32) + (N_BYP + 32);
    localparam int TIMEOUT_NS = TOTAL_CYCLES * CLK_PERIOD + 400;
    localparam int MEM_BYTES = `DMEM_WORDS * 4;
    localparam logic [31:0] WIN_BASE = 32'h0000_0100;

    logic clk;
    logic rst_n;
    logic in_valid;
    word_t in_pc;
    word_t in_alu_out;
    word_t in_br_en;
    word_t in_u_imm;
    word_t in_rs2_v;
    reg_idx_t in_rd_s;
    logic in_mem_we;
    mem_width_t in_mem_width;
    regf_m_sel_t in_regf_m_sel;
    logic in_regf_we;
    reg_idx_t rs1_s;
    reg_idx_t rs2_s;
    word_t rs1_v;
    word_t rs2_v;
    reg_idx_t wb_rd_s;
    word_t wb_rd_v;
    logic wb_regf_we;

    integer seed;
    int checks;
    int errors;
    int tests_run;
    int tests_passed;
    logic [4:0] sweep_idx;

    // reference state of the memory and the register file.
    logic [7:0] mem_model [MEM_BYTES];
    logic [31:0] regs_model [32];

    // instructions in flight with the oldest at the front.
    logic [4:0] q_rd [$];
    logic [31:0] q_val [$];
    logic q_we [$];

    rv32i_backend uut (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic int unsigned rand_below(input int unsigned n);
        return $unsigned($random(seed)) % n;
    endfunction

    task automatic check_word(input string name, input logic [31:0] expv,
                              input logic [31:0] actv);
        checks++;
        assert (actv === expv) else begin
            $display("Mismatch %s: expected %h, got %h", name, expv, actv);
            errors++;
        end
    endtask

    // result an instruction should write back under plain RV32I load rules.
    function automatic logic [31:0] expected_wb(input regf_m_sel_t sel, input logic [31:0] pc,
                                                input logic [31:0] alu, input logic [31:0] bren,
                                                input logic [31:0] uimm);
        int a;
        logic [31:0] w;
        logic [15:0] h;
        logic [7:0] b;
        a = int'(alu) & (MEM_BYTES - 1);
        w = {mem_model[(a & ~3) + 3], mem_model[(a & ~3) + 2],
             mem_model[(a & ~3) + 1], mem_model[a & ~3]};
        h = {mem_model[(a & ~1) + 1], mem_model[a & ~1]};
        b = mem_model[a];
        case (sel)
            alu_out_wb:  return alu;
            br_en_wb:    return bren;
            u_imm_wb:    return uimm;
            pc_plus4_wb: return pc + 32'd4;
            lw_wb:       return w;
            lb_wb:       return {{24{b[7]}}, b};
            lbu_wb:      return {24'd0, b};
            lh_wb:       return {{16{h[15]}}, h};
            lhu_wb:      return {16'd0, h};
            default:     return 32'd0;
        endcase
    endfunction

    task automatic store_model(input mem_width_t mw, input logic [31:0] alu,
                               input logic [31:0] data);
        int a;
        a = int'(alu) & (MEM_BYTES - 1);
        case (mw)
            mem_b: begin
                mem_model[a] = data[7:0];
            end
            mem_h: begin
                mem_model[a & ~1] = data[7:0];
                mem_model[(a & ~1) + 1] = data[15:8];
            end
            mem_w: begin
                for (int i = 0; i < 4; i++) begin
                    mem_model[(a & ~3) + i] = data[8*i +: 8];
                end
            end
            default: begin
            end
        endcase
    endtask

    // checks the write-back, then issues the next instruction and checks reads.
    task automatic step(input logic v, input logic [31:0] pc, input logic [31:0] alu,
                        input logic [31:0] bren, input logic [31:0] uimm,
                        input logic [31:0] data, input logic [4:0] rd, input logic mwe,
                        input mem_width_t mw, input regf_m_sel_t sel, input logic rwe);
        logic [31:0] expv;
        @(negedge clk);
        check_word("wb_regf_we", 32'(q_we[0]), 32'(wb_regf_we));
        if (q_we[0]) begin
            check_word("wb_rd_s", 32'(q_rd[0]), 32'(wb_rd_s));
            check_word("wb_rd_v", q_val[0], wb_rd_v);
            if (q_rd[0] != 5'd0) begin
                regs_model[q_rd[0]] = q_val[0];
            end
        end
        // rs1 follows the write in progress and rs2 walks all registers.
        rs1_s = q_rd[0];
        rs2_s = sweep_idx;
        sweep_idx = sweep_idx + 5'd1;
        void'(q_rd.pop_front());
        void'(q_val.pop_front());
        void'(q_we.pop_front());
        expv = expected_wb(sel, pc, alu, bren, uimm);
        if (v && mwe) begin
            store_model(mw, alu, data);
        end
        q_rd.push_back(rd);
        q_val.push_back(expv);
        q_we.push_back(v && rwe);
        in_valid = v;
        in_pc = pc;
        in_alu_out = alu;
        in_br_en = bren;
        in_u_imm = uimm;
        in_rs2_v = data;
        in_rd_s = rd;
        in_mem_we = mwe;
        in_mem_width = mw;
        in_regf_m_sel = sel;
        in_regf_we = rwe;
        #1;
        check_word("rs1_v", regs_model[rs1_s], rs1_v);
        check_word("rs2_v", regs_model[rs2_s], rs2_v);
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) begin
            step(1'b0, 32'd0, 32'd0, 32'd0, 32'd0, 32'd0, 5'd0, 1'b0, mem_w, alu_out_wb, 1'b0);
        end
    endtask

    function automatic regf_m_sel_t pick_load();
        case (rand_below(5))
            0:       return lw_wb;
            1:       return lb_wb;
            2:       return lbu_wb;
            3:       return lh_wb;
            default: return lhu_wb;
        endcase
    endfunction

    task automatic check_reset();
        for (int r = 0; r < 32; r++) begin
            @(negedge clk);
            rs1_s = 5'(r);
            rs2_s = 5'(31 - r);
            #1;
            check_word("wb_regf_we", 32'd0, 32'(wb_regf_we));
            check_word("rs1_v", 32'd0, rs1_v);
            check_word("rs2_v", 32'd0, rs2_v);
        end
    endtask

    task automatic writeback_sweep();
        regf_m_sel_t sel;
        for (int n = 0; n < N_ALU; n++) begin
            case (rand_below(4))
                0:       sel = alu_out_wb;
                1:       sel = br_en_wb;
                2:       sel = u_imm_wb;
                default: sel = pc_plus4_wb;
            endcase
            step(1'b1, $random(seed), $random(seed), $random(seed), $random(seed),
                 $random(seed), 5'(rand_below(32)), 1'b0, mem_w, sel, 1'b1);
        end
        idle_cycles(32);
    endtask

    task automatic mem_traffic();
        logic [31:0] addr;
        int unsigned kind;
        // every window word gets a known value first.
        for (int w = 0; w < 16; w++) begin
            step(1'b1, 32'd0, WIN_BASE + 32'(w * 4), 32'd0, 32'd0, $random(seed), 5'd0,
                 1'b1, mem_w, alu_out_wb, 1'b0);
        end
        for (int n = 0; n < N_MEM; n++) begin
            addr = WIN_BASE + 32'(rand_below(64));
            kind = rand_below(8);
            if (kind < 3) begin
                step(1'b1, 32'd0, addr, 32'd0, 32'd0, $random(seed), 5'd0, 1'b1,
                     mem_width_t'(kind), alu_out_wb, 1'b0);
                // load of the same word on the very next cycle.
                step(1'b1, 32'd0, {addr[31:2], 2'(rand_below(4))}, 32'd0, 32'd0, 32'd0,
                     5'(rand_below(32)), 1'b0, mem_w, pick_load(), 1'b1);
            end else begin
                step(1'b1, 32'd0, addr, 32'd0, 32'd0, 32'd0, 5'(rand_below(32)), 1'b0,
                     mem_w, pick_load(), 1'b1);
            end
        end
        idle_cycles(32);
    endtask

    task automatic suppressed_traffic();
        logic [31:0] addr;
        for (int n = 0; n < N_SUP; n++) begin
            addr = WIN_BASE + 32'(rand_below(64));
            if (rand_below(2) == 0) begin
                step(1'b0, $random(seed), addr, $random(seed), $random(seed), $random(seed),
                     5'(rand_below(32)), 1'(rand_below(2)), mem_width_t'(rand_below(3)),
                     regf_m_sel_t'(rand_below(9)), 1'b1);
            end else begin
                step(1'b1, $random(seed), addr, $random(seed), $random(seed), $random(seed),
                     5'(rand_below(32)), 1'b0, mem_w, regf_m_sel_t'(rand_below(9)), 1'b0);
            end
        end
        // read back the window to show memory kept its contents.
        for (int w = 0; w < 16; w++) begin
            step(1'b1, 32'd0, WIN_BASE + 32'(w * 4), 32'd0, 32'd0, 32'd0,
                 5'(1 + rand_below(31)), 1'b0, mem_w, lw_wb, 1'b1);
        end
        idle_cycles(32);
    endtask

    task automatic bypass_burst();
        for (int n = 0; n < N_BYP; n++) begin
            step(1'b1, 32'd0, $random(seed), 32'd0, 32'd0, 32'd0, 5'(1 + rand_below(3)),
                 1'b0, mem_w, alu_out_wb, 1'b1);
        end
        idle_cycles(32);
    endtask

    task automatic report_test(input string name, input int errs_before);
        tests_run++;
        if (errors == errs_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, errors - errs_before);
        end
    endtask

    initial begin
        int e;
        seed = 46438;
        checks = 0;
        errors = 0;
        tests_run = 0;
        tests_passed = 0;
        sweep_idx = 5'd0;
        clk = 1'b0;
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_pc = '0;
        in_alu_out = '0;
        in_br_en = '0;
        in_u_imm = '0;
        in_rs2_v = '0;
        in_rd_s = '0;
        in_mem_we = 1'b0;
        in_mem_width = mem_w;
        in_regf_m_sel = alu_out_wb;
        in_regf_we = 1'b0;
        rs1_s = '0;
        rs2_s = '0;
        for (int r = 0; r < 32; r++) begin
            regs_model[r] = 32'd0;
        end
        // both stages hold bubbles after reset.
        repeat (2) begin
            q_rd.push_back(5'd0);
            q_val.push_back(32'd0);
            q_we.push_back(1'b0);
        end
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        e = errors;
        check_reset();
        report_test("reset", e);
        e = errors;
        writeback_sweep();
        report_test("non-memory write-back", e);
        e = errors;
        mem_traffic();
        report_test("stores and loads", e);
        e = errors;
        suppressed_traffic();
        report_test("suppression", e);
        e = errors;
        bypass_burst();
        report_test("bypass", e);

        $display("checks %0d, errors %0d, tests passed %0d of %0d",
                 checks, errors, tests_passed, tests_run);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("run did not finish within %0d ns, stopped by watchdog", TIMEOUT_NS);
        $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

//--- files.f
+incdir+.
rv32i_types.sv
regf_wr_if.sv
data_mem.sv
mem_stage.sv
wb_stage.sv
regfile.sv
rv32i_backend.sv
tb_rv32i_backend.sv

//--- Makefile
VERILATOR = verilator
FLAGS     = --binary --timing
TOP       = tb_rv32i_backend
FILELIST  = files.f
OBJDIR    = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)
	@out="$$(./$(OBJDIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TEST RESULT: PASS"

clean:
	rm -rf $(OBJDIR)
